/* common/uart_settings.svh */
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// number of serial channels in the hub
`define UART_NCH 4

// width of a channel number
`define UART_CH_W ($clog2(`UART_NCH))

// data bits per frame, sent lsb first
`define UART_DATA_BITS 8

// clock cycles per serial bit, even and at least 4
`define UART_CLKS_PER_BIT 8

`endif

/* common/uart_pkg.sv */
package uart_pkg;

`include "uart_settings.svh"

	////////////////////////////////////////////////////////////
	// payload type
	////////////////////////////////////////////////////////////

	// one serial data word
	typedef logic [`UART_DATA_BITS-1:0] uart_byte_t;

	////////////////////////////////////////////////////////////
	// state machines
	////////////////////////////////////////////////////////////

	// transmitter phases of one 8N1 frame
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	// receiver phases
	// start phase rechecks the line at the bit midpoint
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

endpackage

/* common/uart_chan_if.sv */
`timescale 1ns/1ps

interface uart_chan_if import uart_pkg::*; ();

	// transmit request from the dispatcher
	// one-cycle start pulse with its byte
	logic       tx_start;
	uart_byte_t tx_data;

	// transmitter activity level
	logic       tx_busy;

	// receive buffer state of the channel
	// pending stays high until the cycle after rx_take
	logic       rx_pending;
	uart_byte_t rx_data;
	logic       rx_frame_err;
	logic       rx_overrun;

	// one-cycle drain pulse from the collector
	logic       rx_take;

	modport dispatch (
		output tx_start,
		output tx_data,
		input  tx_busy
	);

	modport chan (
		input  tx_start, tx_data, rx_take,
		output tx_busy, rx_pending, rx_data, rx_frame_err, rx_overrun
	);

	modport collect (
		input  rx_pending, rx_data, rx_frame_err, rx_overrun,
		output rx_take
	);

endinterface

/* logic/tx_dispatch.sv */
`timescale 1ns/1ps

`include "uart_settings.svh"

module tx_dispatch import uart_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 wr_strobe,
	input  logic [`UART_CH_W-1:0] wr_chan,
	input  uart_byte_t           wr_data,
	output logic                 wr_drop,
	uart_chan_if.dispatch        chans [`UART_NCH]
);

	localparam int NCH = `UART_NCH;

	logic [NCH-1:0] busy_v;
	logic [NCH-1:0] start_q;
	uart_byte_t     data_q;
	logic           accept;

	// per channel view of busy
	// a start still in flight counts as busy too
	for (genvar i = 0; i < NCH; i++) begin : g_chan
		assign busy_v[i] = chans[i].tx_busy | start_q[i];
		assign chans[i].tx_start = start_q[i];
		// shared byte register that only the started channel reads
		assign chans[i].tx_data = data_q;
	end

	assign accept = wr_strobe && !busy_v[wr_chan];

	// start pulse and drop pulse one cycle after the strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			start_q <= '0;
			wr_drop <= 1'b0;
		end else begin
			start_q <= '0;
			if (accept)
				start_q[wr_chan] <= 1'b1;
			wr_drop <= wr_strobe && !accept;
		end
	end

	// byte to send
	always_ff @(posedge clk) begin
		if (accept)
			data_q <= wr_data;
	end

endmodule

/* uart_channel/uart_tx.sv */
`timescale 1ns/1ps

`include "uart_settings.svh"

module uart_tx import uart_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       start,
	input  uart_byte_t data,
	output logic       busy,
	output logic       line
);

	localparam int CPB   = `UART_CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CPB);
	localparam int BIT_W = $clog2(`UART_DATA_BITS);

	tx_state_t        state_q;
	logic [CNT_W-1:0] baud_q;
	logic [BIT_W-1:0] bit_q;
	uart_byte_t       shift_q;
	logic             bit_end;

	// last cycle of the current bit
	assign bit_end = (baud_q == CNT_W'(CPB - 1));

	// high from the cycle after start to the end of the stop bit
	assign busy = (state_q != TX_IDLE);

	////////////////////////////////////////////////////////////
	// frame sequencer
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= TX_IDLE;
			baud_q  <= '0;
			bit_q   <= '0;
			line    <= 1'b1;
		end else begin
			case (state_q)
				TX_IDLE: begin
					baud_q <= '0;
					// line drops together with busy rising
					if (start) begin
						line    <= 1'b0;
						state_q <= TX_START;
					end
				end
				TX_START: begin
					baud_q <= baud_q + 1'b1;
					if (bit_end) begin
						baud_q  <= '0;
						bit_q   <= '0;
						line    <= shift_q[0];
						state_q <= TX_DATA;
					end
				end
				TX_DATA: begin
					baud_q <= baud_q + 1'b1;
					if (bit_end) begin
						baud_q <= '0;
						if (bit_q == BIT_W'(`UART_DATA_BITS - 1)) begin
							// stop bit is high
							line    <= 1'b1;
							state_q <= TX_STOP;
						end else begin
							bit_q <= bit_q + 1'b1;
							line  <= shift_q[0];
						end
					end
				end
				TX_STOP: begin
					baud_q <= baud_q + 1'b1;
					if (bit_end) begin
						baud_q  <= '0;
						state_q <= TX_IDLE;
					end
				end
				default: state_q <= TX_IDLE;
			endcase
		end
	end

	// lsb first, shifted at each bit boundary
	always_ff @(posedge clk) begin
		if (state_q == TX_IDLE && start)
			shift_q <= data;
		else if (bit_end && (state_q == TX_START || state_q == TX_DATA))
			shift_q <= shift_q >> 1;
	end

endmodule

/* uart_channel/uart_rx.sv */
`timescale 1ns/1ps

`include "uart_settings.svh"

module uart_rx import uart_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       line,
	output logic       done,
	output uart_byte_t data,
	output logic       frame_err
);

	localparam int CPB   = `UART_CLKS_PER_BIT;
	localparam int HALF  = CPB / 2;
	localparam int CNT_W = $clog2(CPB);
	localparam int BIT_W = $clog2(`UART_DATA_BITS);

	logic [1:0]       sync_q;
	logic             line_s;
	rx_state_t        state_q;
	logic [CNT_W-1:0] baud_q;
	logic [BIT_W-1:0] bit_q;
	logic             start_mid;
	logic             bit_mid;

	////////////////////////////////////////////////////////////
	// input synchronizer
	////////////////////////////////////////////////////////////

	// idles high so reset does not look like a start bit
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			sync_q <= 2'b11;
		else
			sync_q <= {sync_q[0], line};
	end

	assign line_s = sync_q[1];

	// half a bit after the falling edge
	assign start_mid = (baud_q == CNT_W'(HALF - 1));
	// one full bit after the previous midpoint
	assign bit_mid = (baud_q == CNT_W'(CPB - 1));

	////////////////////////////////////////////////////////////
	// frame receiver
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= RX_IDLE;
			baud_q  <= '0;
			bit_q   <= '0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state_q)
				RX_IDLE: begin
					baud_q <= '0;
					if (!line_s)
						state_q <= RX_START;
				end
				RX_START: begin
					baud_q <= baud_q + 1'b1;
					if (start_mid) begin
						baud_q <= '0;
						bit_q  <= '0;
						// high at midpoint means a glitch
						state_q <= line_s ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					baud_q <= baud_q + 1'b1;
					if (bit_mid) begin
						baud_q <= '0;
						if (bit_q == BIT_W'(`UART_DATA_BITS - 1))
							state_q <= RX_STOP;
						else
							bit_q <= bit_q + 1'b1;
					end
				end
				RX_STOP: begin
					baud_q <= baud_q + 1'b1;
					// back to idle at the stop midpoint
					// so the next falling edge is caught
					if (bit_mid) begin
						baud_q  <= '0;
						done    <= 1'b1;
						state_q <= RX_IDLE;
					end
				end
				default: state_q <= RX_IDLE;
			endcase
		end
	end

	// lsb arrives first and ends up at bit 0
	always_ff @(posedge clk) begin
		if (state_q == RX_DATA && bit_mid)
			data <= {line_s, data[`UART_DATA_BITS-1:1]};
		if (state_q == RX_STOP && bit_mid)
			frame_err <= ~line_s;
	end

endmodule

/* uart_channel/uart_channel.sv */
`timescale 1ns/1ps

module uart_channel import uart_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     rx,
	output logic     tx,
	uart_chan_if.chan ch
);

	// receiver result
	logic       rx_done;
	uart_byte_t rx_byte;
	logic       rx_ferr;

	// one-byte receive buffer
	logic       pending_q;
	logic       overrun_q;
	logic       ferr_q;
	uart_byte_t data_q;

	////////////////////////////////////////////////////////////
	// serializer and deserializer
	////////////////////////////////////////////////////////////

	uart_tx tx_i (
		.clk   (clk),
		.rst_n (rst_n),
		.start (ch.tx_start),
		.data  (ch.tx_data),
		.busy  (ch.tx_busy),
		.line  (tx)
	);

	uart_rx rx_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.line      (rx),
		.done      (rx_done),
		.data      (rx_byte),
		.frame_err (rx_ferr)
	);

	////////////////////////////////////////////////////////////
	// receive buffer flags
	////////////////////////////////////////////////////////////

	// a new byte on an untaken one is an overrun
	// take in the same cycle as done frees the slot first
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending_q <= 1'b0;
			overrun_q <= 1'b0;
		end else if (rx_done) begin
			pending_q <= 1'b1;
			overrun_q <= (pending_q | overrun_q) & ~ch.rx_take;
		end else if (ch.rx_take) begin
			pending_q <= 1'b0;
			overrun_q <= 1'b0;
		end
	end

	// newer byte replaces the older one
	always_ff @(posedge clk) begin
		if (rx_done) begin
			data_q <= rx_byte;
			ferr_q <= rx_ferr;
		end
	end

	assign ch.rx_pending   = pending_q;
	assign ch.rx_overrun   = overrun_q;
	assign ch.rx_frame_err = ferr_q;
	assign ch.rx_data      = data_q;

endmodule

/* logic/rx_collect.sv */
`timescale 1ns/1ps

`include "uart_settings.svh"

module rx_collect import uart_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  rd_hold,
	uart_chan_if.collect          chans [`UART_NCH],
	output logic                  rd_valid,
	output logic [`UART_CH_W-1:0] rd_chan,
	output uart_byte_t            rd_data,
	output logic                  rd_frame_err,
	output logic                  rd_overrun
);

	localparam int NCH  = `UART_NCH;
	localparam int CH_W = `UART_CH_W;

	logic [NCH-1:0]  pend_v;
	logic [NCH-1:0]  ferr_v;
	logic [NCH-1:0]  ovr_v;
	uart_byte_t      data_v [NCH];
	logic [NCH-1:0]  take_q;
	logic [NCH-1:0]  avail;
	logic [CH_W-1:0] ptr_q;
	logic [CH_W-1:0] pick;
	logic            hit;

	// flatten the channel interfaces
	for (genvar i = 0; i < NCH; i++) begin : g_chan
		assign pend_v[i] = chans[i].rx_pending;
		assign ferr_v[i] = chans[i].rx_frame_err;
		assign ovr_v[i]  = chans[i].rx_overrun;
		assign data_v[i] = chans[i].rx_data;
		assign chans[i].rx_take = take_q[i];
	end

	// pending is still high in the take cycle
	assign avail = pend_v & ~take_q;

	// first available channel at or after the pointer
	always_comb begin
		int cand;
		hit  = 1'b0;
		pick = '0;
		for (int k = 0; k < NCH; k++) begin
			cand = (int'(ptr_q) + k) % NCH;
			if (!hit && avail[cand]) begin
				hit  = 1'b1;
				pick = CH_W'(cand);
			end
		end
	end

	// grant, take pulse and pointer update
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
			take_q   <= '0;
			ptr_q    <= '0;
		end else begin
			rd_valid <= 1'b0;
			take_q   <= '0;
			if (!rd_hold && hit) begin
				rd_valid     <= 1'b1;
				take_q[pick] <= 1'b1;
				ptr_q        <= (int'(pick) == NCH - 1) ? '0 : pick + 1'b1;
			end
		end
	end

	// byte and flags of the granted channel
	always_ff @(posedge clk) begin
		if (!rd_hold && hit) begin
			rd_chan      <= pick;
			rd_data      <= data_v[pick];
			rd_frame_err <= ferr_v[pick];
			rd_overrun   <= ovr_v[pick];
		end
	end

endmodule

/* logic/uart_hub.sv */
`timescale 1ns/1ps

`include "uart_settings.svh"

module uart_hub import uart_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	// host write side
	input  logic                  wr_strobe,
	input  logic [`UART_CH_W-1:0] wr_chan,
	input  uart_byte_t            wr_data,
	output logic                  wr_drop,
	// serial lines
	input  logic [`UART_NCH-1:0]  rx,
	output logic [`UART_NCH-1:0]  tx,
	output logic [`UART_NCH-1:0]  tx_busy,
	// host read side
	input  logic                  rd_hold,
	output logic                  rd_valid,
	output logic [`UART_CH_W-1:0] rd_chan,
	output uart_byte_t            rd_data,
	output logic                  rd_frame_err,
	output logic                  rd_overrun
);

	// one link per channel
	uart_chan_if chan_if [`UART_NCH] ();

	////////////////////////////////////////////////////////////
	// write path
	////////////////////////////////////////////////////////////

	tx_dispatch dispatch_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_strobe (wr_strobe),
		.wr_chan   (wr_chan),
		.wr_data   (wr_data),
		.wr_drop   (wr_drop),
		.chans     (chan_if)
	);

	// identical channels
	for (genvar g = 0; g < `UART_NCH; g++) begin : g_chan
		uart_channel chan_i (
			.clk   (clk),
			.rst_n (rst_n),
			.rx    (rx[g]),
			.tx    (tx[g]),
			.ch    (chan_if[g])
		);

		assign tx_busy[g] = chan_if[g].tx_busy;
	end

	////////////////////////////////////////////////////////////
	// read path
	////////////////////////////////////////////////////////////

	rx_collect collect_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.rd_hold      (rd_hold),
		.chans        (chan_if),
		.rd_valid     (rd_valid),
		.rd_chan      (rd_chan),
		.rd_data      (rd_data),
		.rd_frame_err (rd_frame_err),
		.rd_overrun   (rd_overrun)
	);

endmodule

/* verification/uart_hub_checker.sv */
`timescale 1ns/1ps

`include "uart_settings.svh"

module uart_hub_checker (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  wr_strobe,
	input logic [`UART_CH_W-1:0] wr_chan,
	input logic                  wr_drop,
	input logic [`UART_NCH-1:0]  tx,
	input logic [`UART_NCH-1:0]  tx_busy,
	input logic                  rd_valid,
	input logic [`UART_CH_W-1:0] rd_chan
);

	int fail_cnt;

	initial fail_cnt = 0;

	// idle transmitter sits at the stop level
	idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
		&(tx | tx_busy))
	else begin
		fail_cnt++;
		$error("tx line low on an idle channel");
	end

	// no back to back grant to one channel
	// pending is still high in the take cycle
	no_repeat_grant: assert property (@(posedge clk) disable iff (!rst_n)
		rd_valid |=> !(rd_valid && (rd_chan == $past(rd_chan))))
	else begin
		fail_cnt++;
		$error("rd_valid repeated for channel %0d", rd_chan);
	end

	// drop pulse follows its strobe by one cycle
	// and needs a busy transmitter or a start already in flight
	drop_after_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		wr_drop |-> $past(wr_strobe) &&
			($past(tx_busy[wr_chan]) ||
			($past(wr_strobe, 2) && !$past(wr_drop) &&
			($past(wr_chan, 2) == $past(wr_chan)))))
	else begin
		fail_cnt++;
		$error("wr_drop without a write to a busy channel one cycle earlier");
	end

endmodule

bind uart_hub uart_hub_checker checker_i (.*);

/* verification/tb_uart_hub.sv */
`timescale 1ns/1ps

`include "uart_settings.svh"

module tb_uart_hub;

	localparam int NCH       = `UART_NCH;
	localparam int CH_W      = `UART_CH_W;
	localparam int CPB       = `UART_CLKS_PER_BIT;
	localparam int CLK_NS    = 4;
	localparam int FRAME_CYC = 10 * CPB;
	localparam int MAX_PAT   = 32;

	logic            clk;
	logic            rst_n;
	logic            wr_strobe;
	logic [CH_W-1:0] wr_chan;
	logic [7:0]      wr_data;
	logic            wr_drop;
	logic [NCH-1:0]  rx;
	logic [NCH-1:0]  tx;
	logic [NCH-1:0]  tx_busy;
	logic            rd_hold;
	logic            rd_valid;
	logic [CH_W-1:0] rd_chan;
	logic [7:0]      rd_data;
	logic            rd_frame_err;
	logic            rd_overrun;

	// per channel line source with 1 for the line model and 0 for loopback
	logic [NCH-1:0]  line_sel;
	logic [NCH-1:0]  line_drv;

	// pattern table
	logic [8*16-1:0] pat_name [MAX_PAT];
	logic [8*8-1:0]  pat_op [MAX_PAT];
	int              pat_ch [MAX_PAT];
	logic [7:0]      pat_d0 [MAX_PAT];
	logic [7:0]      pat_d1 [MAX_PAT];
	int              pat_ferr [MAX_PAT];
	int              pat_ovr [MAX_PAT];
	int              npat;
	bit              pats_loaded;

	// received bytes in arrival order
	logic [CH_W-1:0] got_chan [$];
	logic [7:0]      got_data [$];
	logic            got_ferr [$];
	logic            got_ovr [$];

	logic [8*16-1:0] cur_name;
	int              test_errs;
	int              err_total;
	int              tests_run;
	int              tests_failed;
	logic [31:0]     lcg_state;

	uart_hub dut_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.wr_strobe    (wr_strobe),
		.wr_chan      (wr_chan),
		.wr_data      (wr_data),
		.wr_drop      (wr_drop),
		.rx           (rx),
		.tx           (tx),
		.tx_busy      (tx_busy),
		.rd_hold      (rd_hold),
		.rd_valid     (rd_valid),
		.rd_chan      (rd_chan),
		.rd_data      (rd_data),
		.rd_frame_err (rd_frame_err),
		.rd_overrun   (rd_overrun)
	);

	// loopback mux
	assign rx = (line_sel & line_drv) | (~line_sel & tx);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// record every delivered byte
	always @(negedge clk) begin
		if (rst_n && rd_valid) begin
			got_chan.push_back(rd_chan);
			got_data.push_back(rd_data);
			got_ferr.push_back(rd_frame_err);
			got_ovr.push_back(rd_overrun);
		end
	end

	// run limit of 40 frame times per pattern
	initial begin
		int limit_ns;
		wait (pats_loaded);
		limit_ns = npat * 40 * FRAME_CYC * CLK_NS + 2000;
		#(limit_ns);
		$display("timeout: run did not finish within %0d ns", limit_ns);
		$display("Test FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_val(input logic [8*12-1:0] field, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		if (exp_v !== act_v) begin
			$display("CHECK FAILED %0s %0s: expected %0h, actual %0h",
				cur_name, field, exp_v, act_v);
			test_errs++;
		end
	endtask

	task automatic finish_test();
		tests_run++;
		err_total += test_errs;
		if (test_errs == 0) begin
			$display("%0s: passed", cur_name);
		end else begin
			tests_failed++;
			$display("%0s: failed with %0d errors", cur_name, test_errs);
		end
	endtask

	task automatic clear_log();
		@(posedge clk);
		got_chan.delete();
		got_data.delete();
		got_ferr.delete();
		got_ovr.delete();
	endtask

	// polls on the rising edge while the monitor pushes on the falling one
	task automatic wait_entries(input int n, output bit ok);
		int cyc;
		cyc = 0;
		while (got_data.size() < n && cyc < 4 * FRAME_CYC) begin
			@(posedge clk);
			cyc++;
		end
		ok = (got_data.size() >= n);
		if (!ok) begin
			$display("%0s: only %0d of %0d bytes arrived before the wait ran out",
				cur_name, got_data.size(), n);
			test_errs++;
		end
	endtask

	task automatic check_entry(input int idx, input int ch, input logic [7:0] d,
			input int fe, input int ov);
		check_val("channel", ch, got_chan[idx]);
		check_val("data", d, got_data[idx]);
		check_val("frame_err", fe, got_ferr[idx]);
		check_val("overrun", ov, got_ovr[idx]);
	endtask

	task automatic write_byte(input int ch, input logic [7:0] d);
		@(posedge clk);
		wr_strobe <= 1'b1;
		wr_chan   <= CH_W'(ch);
		wr_data   <= d;
		@(posedge clk);
		wr_strobe <= 1'b0;
	endtask

	// 8N1 frame lsb first followed by two idle bit times
	task automatic send_frame(input int ch, input logic [7:0] d, input logic stop);
		logic [9:0] bits;
		bits = {stop, d, 1'b0};
		@(posedge clk);
		for (int b = 0; b < 10; b++) begin
			line_drv[ch] <= bits[b];
			repeat (CPB) @(posedge clk);
		end
		line_drv[ch] <= 1'b1;
		repeat (2 * CPB) @(posedge clk);
	endtask

	task automatic check_idle_outputs();
		check_val("tx", {NCH{1'b1}}, tx);
		check_val("tx_busy", 0, tx_busy);
		check_val("wr_drop", 0, wr_drop);
		check_val("rd_valid", 0, rd_valid);
	endtask

	task automatic load_patterns();
		int fd;
		int rc;
		int ch;
		int fe;
		int ov;
		logic [8*16-1:0]  tok;
		logic [8*8-1:0]   op;
		logic [7:0]       d0;
		logic [7:0]       d1;
		logic [8*128-1:0] rest;
		npat = 0;
		fd = $fopen("verification/uart_patterns.txt", "r");
		if (fd == 0) begin
			$display("cannot open pattern file verification/uart_patterns.txt");
			err_total++;
		end else begin
			rc = $fscanf(fd, "%s", tok);
			while (rc == 1 && npat < MAX_PAT) begin
				if (tok == "#") begin
					rc = $fgets(rest, fd);
				end else begin
					rc = $fscanf(fd, "%s %d %h %h %d %d", op, ch, d0, d1, fe, ov);
					if (rc == 6) begin
						pat_name[npat] = tok;
						pat_op[npat]   = op;
						pat_ch[npat]   = ch;
						pat_d0[npat]   = d0;
						pat_d1[npat]   = d1;
						pat_ferr[npat] = fe;
						pat_ovr[npat]  = ov;
						npat++;
					end else begin
						$display("pattern %0s has missing fields", tok);
						err_total++;
					end
				end
				rc = $fscanf(fd, "%s", tok);
			end
			$fclose(fd);
		end
		if (npat == 0) begin
			$display("pattern file holds no tests");
			err_total++;
		end
		pats_loaded = 1'b1;
	endtask

	////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////

	task automatic run_loop(input int p);
		bit ok;
		clear_log();
		write_byte(pat_ch[p], pat_d0[p]);
		wait_entries(1, ok);
		if (ok)
			check_entry(0, pat_ch[p], pat_d0[p], pat_ferr[p], pat_ovr[p]);
	endtask

	// every channel written in back to back cycles
	task automatic run_burst(input int p);
		logic [7:0] exp_d [NCH];
		int c;
		int hits;
		bit ok;
		clear_log();
		for (int k = 0; k < NCH; k++) begin
			c = (pat_ch[p] + k) % NCH;
			if (k == 0) begin
				exp_d[c] = pat_d0[p];
			end else begin
				lcg_state = lcg_next(lcg_state);
				exp_d[c]  = lcg_state[23:16];
			end
		end
		@(posedge clk);
		for (int k = 0; k < NCH; k++) begin
			c = (pat_ch[p] + k) % NCH;
			wr_strobe <= 1'b1;
			wr_chan   <= CH_W'(c);
			wr_data   <= exp_d[c];
			@(posedge clk);
		end
		wr_strobe <= 1'b0;
		wait_entries(NCH, ok);
		repeat (FRAME_CYC) @(posedge clk);
		check_val("count", NCH, got_data.size());
		// exactly one byte per channel in any order
		for (int ch = 0; ch < NCH; ch++) begin
			hits = 0;
			for (int i = 0; i < got_data.size(); i++) begin
				if (got_chan[i] == CH_W'(ch)) begin
					hits++;
					check_entry(i, ch, exp_d[ch], pat_ferr[p], pat_ovr[p]);
				end
			end
			check_val("hits", 1, hits);
		end
	endtask

	task automatic run_busy(input int p);
		int ch;
		int cyc;
		bit ok;
		ch = pat_ch[p];
		clear_log();
		write_byte(ch, pat_d0[p]);
		cyc = 0;
		while (!tx_busy[ch] && cyc < 16) begin
			@(negedge clk);
			cyc++;
		end
		check_val("tx_busy", 1, tx_busy[ch]);
		// second write lands on a busy transmitter
		write_byte(ch, pat_d1[p]);
		@(negedge clk);
		check_val("wr_drop", 1, wr_drop);
		wait_entries(1, ok);
		if (ok)
			check_entry(0, ch, pat_d0[p], pat_ferr[p], pat_ovr[p]);
		repeat (2 * FRAME_CYC) @(posedge clk);
		check_val("count", 1, got_data.size());
	endtask

	task automatic run_frame(input int p);
		int ch;
		bit ok;
		ch = pat_ch[p];
		clear_log();
		line_sel[ch] <= 1'b1;
		// low stop bit first and a clean frame after it
		send_frame(ch, pat_d0[p], 1'b0);
		wait_entries(1, ok);
		if (ok)
			check_entry(0, ch, pat_d0[p], pat_ferr[p], pat_ovr[p]);
		send_frame(ch, pat_d1[p], 1'b1);
		wait_entries(2, ok);
		if (ok)
			check_entry(1, ch, pat_d1[p], 0, 0);
		@(posedge clk);
		line_sel[ch] <= 1'b0;
	endtask

	task automatic run_overrun(input int p);
		int ch;
		bit ok;
		ch = pat_ch[p];
		clear_log();
		rd_hold      <= 1'b1;
		line_sel[ch] <= 1'b1;
		send_frame(ch, pat_d0[p], 1'b1);
		send_frame(ch, pat_d1[p], 1'b1);
		check_val("held count", 0, got_data.size());
		@(posedge clk);
		rd_hold <= 1'b0;
		// newer byte survives with the overrun flag
		wait_entries(1, ok);
		if (ok)
			check_entry(0, ch, pat_d1[p], pat_ferr[p], pat_ovr[p]);
		repeat (FRAME_CYC) @(posedge clk);
		check_val("count", 1, got_data.size());
		line_sel[ch] <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		rst_n        = 1'b0;
		wr_strobe    = 1'b0;
		wr_chan      = '0;
		wr_data      = '0;
		rd_hold      = 1'b0;
		line_sel     = '0;
		line_drv     = '1;
		pats_loaded  = 1'b0;
		npat         = 0;
		err_total    = 0;
		tests_run    = 0;
		tests_failed = 0;
		lcg_state    = 32'h856925db;

		load_patterns();

		// idle outputs in and right after reset
		cur_name  = "reset_state";
		test_errs = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		check_idle_outputs();
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(negedge clk);
		check_idle_outputs();
		finish_test();

		for (int p = 0; p < npat; p++) begin
			cur_name  = pat_name[p];
			test_errs = 0;
			if (pat_op[p] == "loop")
				run_loop(p);
			else if (pat_op[p] == "burst")
				run_burst(p);
			else if (pat_op[p] == "busy")
				run_busy(p);
			else if (pat_op[p] == "frame")
				run_frame(p);
			else if (pat_op[p] == "overrun")
				run_overrun(p);
			else begin
				$display("%0s: unknown operation %0s", cur_name, pat_op[p]);
				test_errs++;
			end
			finish_test();
		end

		repeat (4) @(posedge clk);
		if (dut_i.checker_i.fail_cnt != 0) begin
			$display("%0d assertion failures", dut_i.checker_i.fail_cnt);
			err_total += dut_i.checker_i.fail_cnt;
		end
		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_total);
		if (err_total == 0 && tests_failed == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* verification/uart_patterns.txt */
# name op chan data0 data1 exp_frame_err exp_overrun
# data in hex, burst fills the remaining channels from the lcg
loop_ch0 loop 0 a5 00 0 0
loop_ch1 loop 1 3c 00 0 0
loop_ch2 loop 2 f0 00 0 0
loop_ch3 loop 3 0f 00 0 0
burst_a burst 0 55 00 0 0
burst_b burst 2 81 00 0 0
busy_ch1 busy 1 12 34 0 0
busy_ch3 busy 3 ff 00 0 0
frame_ch2 frame 2 c3 7e 1 0
frame_ch0 frame 0 00 ff 1 0
ovr_ch1 overrun 1 11 22 0 1
ovr_ch3 overrun 3 e7 18 0 1
loop_end loop 2 69 00 0 0

/* build.f */
+incdir+common
common/uart_pkg.sv
common/uart_chan_if.sv
logic/tx_dispatch.sv
uart_channel/uart_tx.sv
uart_channel/uart_rx.sv
uart_channel/uart_channel.sv
logic/rx_collect.sv
logic/uart_hub.sv
verification/uart_hub_checker.sv
verification/tb_uart_hub.sv
